/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = display_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal, the pass line decides the status
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* design/apb_pixel_port.sv */
`timescale 1ns/1ps
`include "display_defines.svh"

module apb_pixel_port
    import display_pkg::*;
(
    input  logic        clk_display,
    input  logic        rstn_display,
    input  apb_req_t    apb,
    output logic        pready,
    output logic [31:0] prdata,
    output logic        pslverr,
    output fb_write_t   pixel_write,
    output logic        swap_request,
    input  logic        swap_pending,
    input  logic        front_select
);

    localparam int unsigned FB_PIXELS = `FB_WIDTH * `FB_HEIGHT;

    logic                       setup;
    logic                       access;
    logic                       is_reg;
    logic [`APB_ADDR_WIDTH-1:0] reg_offset;
    logic [`FB_ADDR_WIDTH-1:0]  pixel_index;
    logic                       pixel_ok;
    logic                       is_ctrl;
    logic                       is_status;
    logic                       write_hold;
    apb_wdata_u                 wdata;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    assign setup  = apb.psel && !apb.penable;
    assign access = apb.psel && apb.penable;

    assign is_reg      = apb.paddr[`APB_ADDR_WIDTH-1];
    assign reg_offset  = apb.paddr - `APB_REG_BASE;
    assign pixel_index = apb.paddr[`FB_ADDR_WIDTH-1:0];

    assign pixel_ok  = !is_reg && (pixel_index < `FB_ADDR_WIDTH'(FB_PIXELS));
    assign is_ctrl   = is_reg && (reg_offset == `APB_ADDR_WIDTH'(`APB_CTRL_OFFSET));
    assign is_status = is_reg && (reg_offset == `APB_ADDR_WIDTH'(`APB_STATUS_OFFSET));

    assign wdata = apb.pwdata;

    ////////////////////////////////////////
    // Response
    ////////////////////////////////////////

    // Back buffer is about to go on screen, so pixel writes wait
    assign write_hold = pixel_ok && apb.pwrite && swap_pending;

    assign pready  = access && !write_hold;
    assign pslverr = pready && !(pixel_ok || is_ctrl || is_status);

    // Buffer write and swap pulse in the completing access cycle
    assign pixel_write.en   = pready && apb.pwrite && pixel_ok;
    assign pixel_write.addr = pixel_index;
    assign pixel_write.data = wdata.pixel.color;

    assign swap_request = pready && apb.pwrite && is_ctrl && wdata.ctrl.swap;

    // Read data taken in the setup cycle, held through the access
    always_ff @(posedge clk_display) begin
        if (setup) begin
            if (!apb.pwrite && is_status) begin
                prdata <= {30'd0, front_select, swap_pending};
            end else begin
                prdata <= '0;
            end
        end
    end

    // Access phase must follow a setup cycle of the same transfer
    a_setup_before_access: assert property (
        @(posedge clk_display) disable iff (!rstn_display)
        $rose(apb.penable) |-> apb.psel && $past(apb.psel)
    );

    // Pending is raised by the swap controller one edge after the request
    a_no_write_while_pending: assert property (
        @(posedge clk_display) disable iff (!rstn_display)
        pixel_write.en |-> !swap_pending && !$past(swap_request)
    );

endmodule

/* design/buffer_swap_ctrl.sv */
`timescale 1ns/1ps
`include "display_defines.svh"

module buffer_swap_ctrl
    import display_pkg::*;
(
    input  logic                      clk_display,
    input  logic                      rstn_display,
    input  fb_write_t                 pixel_write,
    input  logic                      swap_request,
    input  logic                      frame_start,
    input  logic [`FB_ADDR_WIDTH-1:0] read_addr,
    output rgb_t                      read_data,
    output fb_write_t                 write_a,
    output fb_write_t                 write_b,
    output logic [`FB_ADDR_WIDTH-1:0] read_addr_a,
    output logic [`FB_ADDR_WIDTH-1:0] read_addr_b,
    input  rgb_t                      read_data_a,
    input  rgb_t                      read_data_b,
    output logic                      swap_pending,
    output logic                      front_select
);

    logic swap_now;
    logic read_select;

    assign swap_now = frame_start && swap_pending;

    // Front select 0 shows buffer A, 1 shows buffer B
    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            swap_pending <= 1'b0;
            front_select <= 1'b0;
            read_select  <= 1'b0;
        end else begin
            // A request on the swap edge stays pending for the next frame
            swap_pending <= swap_request || (swap_pending && !frame_start);
            if (swap_now) begin
                front_select <= !front_select;
            end
            // Follows the buffer's one-cycle read latency
            read_select <= front_select;
        end
    end

    ////////////////////////////////////////
    // Buffer routing
    ////////////////////////////////////////

    // Writes go to the back buffer only
    always_comb begin
        write_a    = pixel_write;
        write_b    = pixel_write;
        write_a.en = pixel_write.en && front_select;
        write_b.en = pixel_write.en && !front_select;
    end

    assign read_addr_a = front_select ? '0 : read_addr;
    assign read_addr_b = front_select ? read_addr : '0;

    assign read_data = read_select ? read_data_b : read_data_a;

    a_swap_only_on_frame: assert property (
        @(posedge clk_display) disable iff (!rstn_display)
        $changed(front_select) |-> $past(frame_start && swap_pending)
    );

endmodule

/* design/display_defines.svh */
`ifndef DISPLAY_DEFINES_SVH
`define DISPLAY_DEFINES_SVH

////////////////////////////////////////
// Frame buffer geometry
////////////////////////////////////////

`define FB_WIDTH        160
`define FB_HEIGHT       120
`define FB_ADDR_WIDTH   15
// Each buffer pixel covers a 4x4 block on screen
`define FB_SCALE        4

////////////////////////////////////////
// 640x480 at 60 Hz timing
////////////////////////////////////////

`define H_ACTIVE        640
`define H_SYNC_START    656
`define H_SYNC_END      752
`define H_TOTAL         800

`define V_ACTIVE        480
`define V_SYNC_START    490
`define V_SYNC_END      492
`define V_TOTAL         525

// APB map, bit 15 splits pixel space from register space
`define APB_ADDR_WIDTH      16
`define APB_REG_BASE        16'h8000
`define APB_CTRL_OFFSET     0
`define APB_STATUS_OFFSET   4

`endif

/* design/display_pkg.sv */
`include "display_defines.svh"

package display_pkg;

    // RGB444 pixel
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // APB request from the host
    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`APB_ADDR_WIDTH-1:0] paddr;
        logic [31:0]                pwdata;
    } apb_req_t;

    // One buffer write, valid while en is high
    typedef struct packed {
        logic                      en;
        logic [`FB_ADDR_WIDTH-1:0] addr;
        rgb_t                      data;
    } fb_write_t;

    // APB write word, read as a pixel or as a control word
    typedef union packed {
        struct packed {
            logic [19:0] unused;
            rgb_t        color;
        } pixel;
        struct packed {
            logic [30:0] unused;
            logic        swap;
        } ctrl;
    } apb_wdata_u;

endpackage

/* design/display_top.sv */
`timescale 1ns/1ps
`include "display_defines.svh"

module display_top
    import display_pkg::*;
(
    input  logic        clk_display,
    input  logic        rstn_display,
    input  apb_req_t    apb,
    output logic        pready,
    output logic [31:0] prdata,
    output logic        pslverr,
    output logic        vga_hsync,
    output logic        vga_vsync,
    output rgb_t        vga_color
);

    fb_write_t                 pixel_write;
    logic                      swap_request;
    logic                      swap_pending;
    logic                      front_select;
    logic                      frame_start;
    logic [`FB_ADDR_WIDTH-1:0] read_addr;
    rgb_t                      read_data;
    fb_write_t                 write_a;
    fb_write_t                 write_b;
    logic [`FB_ADDR_WIDTH-1:0] read_addr_a;
    logic [`FB_ADDR_WIDTH-1:0] read_addr_b;
    rgb_t                      read_data_a;
    rgb_t                      read_data_b;

    ////////////////////////////////////////
    // Host side
    ////////////////////////////////////////

    apb_pixel_port apb_pixel_port_inst (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .apb          (apb),
        .pready       (pready),
        .prdata       (prdata),
        .pslverr      (pslverr),
        .pixel_write  (pixel_write),
        .swap_request (swap_request),
        .swap_pending (swap_pending),
        .front_select (front_select)
    );

    buffer_swap_ctrl buffer_swap_ctrl_inst (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .pixel_write  (pixel_write),
        .swap_request (swap_request),
        .frame_start  (frame_start),
        .read_addr    (read_addr),
        .read_data    (read_data),
        .write_a      (write_a),
        .write_b      (write_b),
        .read_addr_a  (read_addr_a),
        .read_addr_b  (read_addr_b),
        .read_data_a  (read_data_a),
        .read_data_b  (read_data_b),
        .swap_pending (swap_pending),
        .front_select (front_select)
    );

    ////////////////////////////////////////
    // Buffers and display
    ////////////////////////////////////////

    frame_buffer frame_buffer_a (
        .clk_display (clk_display),
        .write       (write_a),
        .read_addr   (read_addr_a),
        .read_data   (read_data_a)
    );

    frame_buffer frame_buffer_b (
        .clk_display (clk_display),
        .write       (write_b),
        .read_addr   (read_addr_b),
        .read_data   (read_data_b)
    );

    vga_scanout vga_scanout_inst (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .read_addr    (read_addr),
        .read_data    (read_data),
        .frame_start  (frame_start),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_color    (vga_color)
    );

endmodule

/* design/frame_buffer.sv */
`timescale 1ns/1ps
`include "display_defines.svh"

module frame_buffer
    import display_pkg::*;
(
    input  logic                      clk_display,
    input  fb_write_t                 write,
    input  logic [`FB_ADDR_WIDTH-1:0] read_addr,
    output rgb_t                      read_data
);

    localparam int unsigned DEPTH = `FB_WIDTH * `FB_HEIGHT;

    rgb_t mem [DEPTH];

    always_ff @(posedge clk_display) begin
        if (write.en) begin
            mem[write.addr] <= write.data;
        end
    end

    // Registered read, one cycle of latency
    always_ff @(posedge clk_display) begin
        read_data <= mem[read_addr];
    end

    // Range is checked by the APB port before the write gets here
    a_write_in_range: assert property (
        @(posedge clk_display) write.en |-> (write.addr < `FB_ADDR_WIDTH'(DEPTH))
    );

endmodule

/* design/vga_scanout.sv */
`timescale 1ns/1ps
`include "display_defines.svh"

module vga_scanout
    import display_pkg::*;
(
    input  logic                      clk_display,
    input  logic                      rstn_display,
    output logic [`FB_ADDR_WIDTH-1:0] read_addr,
    input  rgb_t                      read_data,
    output logic                      frame_start,
    output logic                      vga_hsync,
    output logic                      vga_vsync,
    output rgb_t                      vga_color
);

    logic [9:0] h_count;
    logic [9:0] v_count;
    logic [9:0] pixel_col;
    logic [9:0] pixel_row;
    logic       active;
    logic       hsync_raw;
    logic       vsync_raw;

    // Two stage delay to line up with the buffer read
    logic [1:0] active_q;
    logic [1:0] hsync_q;
    logic [1:0] vsync_q;

    ////////////////////////////////////////
    // Screen counters
    ////////////////////////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == 10'(`H_TOTAL - 1)) begin
            h_count <= '0;
            if (v_count == 10'(`V_TOTAL - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 10'd1;
            end
        end else begin
            h_count <= h_count + 10'd1;
        end
    end

    assign active = (h_count < 10'(`H_ACTIVE)) && (v_count < 10'(`V_ACTIVE));

    // Active-low syncs
    assign hsync_raw = !((h_count >= 10'(`H_SYNC_START)) && (h_count < 10'(`H_SYNC_END)));
    assign vsync_raw = !((v_count >= 10'(`V_SYNC_START)) && (v_count < 10'(`V_SYNC_END)));

    // First cycle of the vertical sync line
    assign frame_start = (h_count == '0) && (v_count == 10'(`V_SYNC_START));

    ////////////////////////////////////////
    // Buffer address and pipeline
    ////////////////////////////////////////

    assign pixel_col = h_count / `FB_SCALE;
    assign pixel_row = v_count / `FB_SCALE;

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            read_addr <= '0;
            active_q  <= '0;
            hsync_q   <= '1;
            vsync_q   <= '1;
        end else begin
            // Keep the address inside the buffer during blanking
            if (active) begin
                read_addr <= `FB_ADDR_WIDTH'(pixel_row * `FB_WIDTH + pixel_col);
            end else begin
                read_addr <= '0;
            end
            active_q <= {active_q[0], active};
            hsync_q  <= {hsync_q[0], hsync_raw};
            vsync_q  <= {vsync_q[0], vsync_raw};
        end
    end

    assign vga_hsync = hsync_q[1];
    assign vga_vsync = vsync_q[1];

    // Blank outside the visible area
    assign vga_color = active_q[1] ? read_data : '0;

endmodule

/* sources.f */
+incdir+design
design/display_pkg.sv
design/frame_buffer.sv
design/apb_pixel_port.sv
design/buffer_swap_ctrl.sv
design/vga_scanout.sv
design/display_top.sv
test/display_tb.sv

/* test/display_tb.sv */
`timescale 1ns/1ps
`include "display_defines.svh"

module display_tb
    import display_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 16;
    localparam int FB_PIXELS    = `FB_WIDTH * `FB_HEIGHT;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int NUM_PIXELS   = 12;
    localparam int BLANK_COLUMN = 700;

    // Tests span about six frames, three more as margin
    localparam longint WATCHDOG_NS = 64'(9) * FRAME_CYCLES * CLK_PERIOD;

    localparam logic [15:0] CTRL_ADDR   = 16'(`APB_REG_BASE + `APB_CTRL_OFFSET);
    localparam logic [15:0] STATUS_ADDR = 16'(`APB_REG_BASE + `APB_STATUS_OFFSET);

    logic        clk_display;
    logic        rstn_display;
    apb_req_t    apb;
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
    logic        vga_hsync;
    logic        vga_vsync;
    rgb_t        vga_color;

    int   errors;
    // Expected back buffer contents, keyed by pixel index
    rgb_t written [int];
    rgb_t screen [`V_ACTIVE * `H_TOTAL];
    rgb_t saved_screen [`V_ACTIVE * `H_TOTAL];

    display_top DUT (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .apb          (apb),
        .pready       (pready),
        .prdata       (prdata),
        .pslverr      (pslverr),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_color    (vga_color)
    );

    initial begin
        clk_display = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_display = ~clk_display;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, tests still running after %0d ns with %0d errors", WATCHDOG_NS, errors);
        $display("** FAIL **");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("error %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
        end
    endtask

    // Setup cycle, then access cycles until pready, sampled mid-cycle
    task automatic apb_transfer(input logic is_write, input logic [15:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err, output int waits);
        @(posedge clk_display);
        #(DRIVE_DELAY);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = is_write;
        apb.paddr   = addr;
        apb.pwdata  = wdata;
        @(posedge clk_display);
        #(DRIVE_DELAY);
        apb.penable = 1'b1;
        waits = 0;
        @(negedge clk_display);
        while (!pready) begin
            waits++;
            @(negedge clk_display);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk_display);
        #(DRIVE_DELAY);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [15:0] addr, input logic [31:0] data,
                             output logic err, output int waits);
        logic [31:0] unused_rdata;
        apb_transfer(1'b1, addr, data, unused_rdata, err, waits);
    endtask

    task automatic apb_read(input logic [15:0] addr, output logic [31:0] data,
                            output logic err);
        int waits;
        apb_transfer(1'b0, addr, '0, data, err, waits);
    endtask

    function automatic logic [31:0] pixel_word(input rgb_t color);
        apb_wdata_u word;
        word = '0;
        word.pixel.color = color;
        return word;
    endfunction

    function automatic logic [31:0] swap_word();
        apb_wdata_u word;
        word = '0;
        word.ctrl.swap = 1'b1;
        return word;
    endfunction

    task automatic check_status(input logic [31:0] expected);
        logic [31:0] data;
        logic        err;
        apb_read(STATUS_ADDR, data, err);
        check_value("prdata status", data, expected);
        check_value("pslverr", 32'(err), 32'd0);
    endtask

    task automatic request_swap();
        logic err;
        int   waits;
        apb_write(CTRL_ADDR, swap_word(), err, waits);
        check_value("pslverr", 32'(err), 32'd0);
    endtask

    task automatic write_pixel(input int idx, input rgb_t color, output int waits);
        logic err;
        apb_write(16'(idx), pixel_word(color), err, waits);
        check_value("pslverr", 32'(err), 32'd0);
        written[idx] = color;
    endtask

    // New index each time, colors never zero so blanking is visible
    task automatic write_random_pixel(output int waits);
        int   idx;
        rgb_t color;
        do begin
            idx = int'($urandom % FB_PIXELS);
        end while (written.exists(idx));
        color = 12'(($urandom % 4095) + 1);
        write_pixel(idx, color, waits);
    endtask

    task automatic measure_hsync_period(output int period);
        logic prev;
        int   count;
        int   falls;
        period = 0;
        count  = 0;
        falls  = 0;
        @(negedge clk_display);
        prev = vga_hsync;
        while (falls < 2) begin
            @(negedge clk_display);
            count++;
            if (prev && !vga_hsync) begin
                if (falls == 1) begin
                    period = count;
                end
                falls++;
                count = 0;
            end
            prev = vga_hsync;
        end
    endtask

    // Syncs and colors share the pipeline delay, so the first visible
    // pixel comes 35 lines after vsync falls at the port
    task automatic capture_frame();
        @(negedge vga_vsync);
        repeat ((`V_TOTAL - `V_SYNC_START) * `H_TOTAL) @(negedge clk_display);
        for (int y = 0; y < `V_ACTIVE; y++) begin
            for (int x = 0; x < `H_TOTAL; x++) begin
                @(negedge clk_display);
                screen[y * `H_TOTAL + x] = vga_color;
            end
        end
    endtask

    task automatic check_written();
        int row;
        int col;
        foreach (written[idx]) begin
            row = idx / `FB_WIDTH * `FB_SCALE;
            col = idx % `FB_WIDTH * `FB_SCALE;
            for (int dy = 0; dy < `FB_SCALE; dy++) begin
                for (int dx = 0; dx < `FB_SCALE; dx++) begin
                    check_value("vga_color", 32'(screen[(row + dy) * `H_TOTAL + col + dx]),
                                32'(written[idx]));
                end
            end
        end
    endtask

    task automatic check_frame_unchanged();
        for (int y = 0; y < `V_ACTIVE; y++) begin
            for (int x = 0; x < `H_ACTIVE; x++) begin
                check_value("vga_color", 32'(screen[y * `H_TOTAL + x]),
                            32'(saved_screen[y * `H_TOTAL + x]));
            end
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_reset_state();
        int period;
        check_value("vga_hsync", 32'(vga_hsync), 32'd1);
        check_value("vga_vsync", 32'(vga_vsync), 32'd1);
        check_value("vga_color", 32'(vga_color), 32'd0);
        check_value("pready", 32'(pready), 32'd0);
        check_value("pslverr", 32'(pslverr), 32'd0);
        check_status(32'd0);
        measure_hsync_period(period);
        check_value("hsync period", period, `H_TOTAL);
    endtask

    task automatic test_swap_shows_back();
        int waits;
        capture_frame();
        saved_screen = screen;
        // The scanout reads pixel 0 during blanking
        write_pixel(0, 12'h5a3, waits);
        check_value("pready wait cycles", waits, 32'd0);
        for (int i = 0; i < NUM_PIXELS; i++) begin
            write_random_pixel(waits);
            check_value("pready wait cycles", waits, 32'd0);
        end
        // Buffer B is still hidden
        capture_frame();
        check_frame_unchanged();
        request_swap();
        capture_frame();
        check_written();
        check_status(32'h2);
    endtask

    task automatic test_write_during_swap();
        int waits;
        request_swap();
        check_status(32'h3);
        write_random_pixel(waits);
        // Released on the swap edge, as vsync falls at the port
        check_value("vga_vsync", 32'(vga_vsync), 32'd0);
        if (waits == 0) begin
            errors++;
            $display("Pixel write completed at once although a swap was pending");
        end
        check_status(32'h0);
        request_swap();
        capture_frame();
        check_written();
        check_status(32'h2);
    endtask

    task automatic test_error_response();
        logic [31:0] data;
        logic        err;
        int          waits;
        saved_screen = screen;
        apb_write(16'(`APB_REG_BASE + 8), swap_word(), err, waits);
        check_value("pslverr", 32'(err), 32'd1);
        apb_read(16'(`APB_REG_BASE + 12), data, err);
        check_value("pslverr", 32'(err), 32'd1);
        apb_write(16'(FB_PIXELS), pixel_word(12'hfff), err, waits);
        check_value("pslverr", 32'(err), 32'd1);
        check_status(32'h2);
        capture_frame();
        check_frame_unchanged();
    endtask

    // Uses the last captured frame, rows with written pixels
    task automatic test_blanking();
        int row;
        foreach (written[idx]) begin
            row = idx / `FB_WIDTH * `FB_SCALE;
            check_value("vga_color", 32'(screen[row * `H_TOTAL + BLANK_COLUMN]), 32'd0);
        end
    endtask

    initial begin
        int seed_result;
        errors       = 0;
        apb          = '0;
        rstn_display = 1'b0;
        seed_result  = $urandom(32'h892);
        repeat (RESET_CYCLES) @(posedge clk_display);
        #(DRIVE_DELAY);
        rstn_display = 1'b1;

        test_reset_state();
        test_swap_shows_back();
        test_write_during_swap();
        test_error_response();
        test_blanking();

        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
